/* src/sgen_defs.svh */
// --------------------------------------------------
// Width definitions for the burst sine/cosine
// generator: phase, table, burst length and
// attenuation sizes.
// --------------------------------------------------
`ifndef SGEN_DEFS_SVH
`define SGEN_DEFS_SVH

// phase accumulator and frequency control word width.
`define SGEN_PHASE_W 16

// table address bits, giving 32 entries per octant.
`define SGEN_ROM_AW 5

// unsigned table magnitude width; signed waves are one bit wider.
`define SGEN_ROM_DW 8

// burst length counter width.
`define SGEN_LEN_W 12

// attenuation shift amount, 0 to 3.
`define SGEN_ATT_W 2

`endif

/* src/sgen_pkg.sv */
// --------------------------------------------------
// Shared types of the burst sine/cosine generator.
// --------------------------------------------------
`include "sgen_defs.svh"

package sgen_pkg;

  // phase value and frequency control word.
  typedef logic [`SGEN_PHASE_W-1:0] phase_t;

  // octant table address and unsigned table magnitude.
  typedef logic [`SGEN_ROM_AW-1:0] rom_addr_t;
  typedef logic [`SGEN_ROM_DW-1:0] rom_data_t;

  // signed full-wave sample, one bit wider than the magnitude.
  typedef logic signed [`SGEN_ROM_DW:0] wave_t;

  typedef logic [`SGEN_LEN_W-1:0] burst_len_t;
  typedef logic [`SGEN_ATT_W-1:0] atten_t;

  // burst control states.
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUN,
    ST_DONE
  } ctrl_state_t;

endpackage

/* src/sgen_ctrl.sv */
`timescale 1ns/1ps
// --------------------------------------------------
// Burst controller of the signal generator. Runs
// the accumulator for N samples, or until a stop
// request when N is zero, and flags completion.
// --------------------------------------------------

module sgen_ctrl (
  input  logic                 i_clk,
  input  logic                 i_rst_an,
  input  logic                 i_start,
  input  logic                 i_stop,
  input  sgen_pkg::burst_len_t i_burst_len,
  output logic                 o_accu_clr,
  output logic                 o_accu_ena,
  output logic                 o_busy,
  output logic                 o_done
);

  sgen_pkg::ctrl_state_t state_q;
  sgen_pkg::ctrl_state_t state_d;
  sgen_pkg::burst_len_t  cnt_q;
  logic                  cont_q;
  logic                  start_ok;
  logic                  last_smp;

  // a start request only counts while idle.
  assign start_ok = (state_q == sgen_pkg::ST_IDLE) && i_start;

  // in counted mode the run ends with the sample that empties the counter.
  assign last_smp = !cont_q && (cnt_q == sgen_pkg::burst_len_t'(1));

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      sgen_pkg::ST_IDLE:
      begin
        if (i_start)
        begin
          state_d = sgen_pkg::ST_RUN;
        end
      end
      sgen_pkg::ST_RUN:
      begin
        if (i_stop || last_smp)
        begin
          state_d = sgen_pkg::ST_DONE;
        end
      end
      sgen_pkg::ST_DONE:
      begin
        state_d = sgen_pkg::ST_IDLE;
      end
      default:
      begin
        state_d = sgen_pkg::ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_an)
  begin
    if (!i_rst_an)
    begin
      state_q <= sgen_pkg::ST_IDLE;
      cnt_q   <= '0;
      cont_q  <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      if (start_ok)
      begin
        cnt_q  <= i_burst_len;
        cont_q <= (i_burst_len == '0);
      end
      else if (o_accu_ena && !cont_q)
      begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // the stop cycle itself produces no sample.
  assign o_accu_clr = start_ok;
  assign o_accu_ena = (state_q == sgen_pkg::ST_RUN) && !i_stop;
  assign o_busy     = (state_q == sgen_pkg::ST_RUN);
  assign o_done     = (state_q == sgen_pkg::ST_DONE);

endmodule

/* src/sgen_phase_accu.sv */
`timescale 1ns/1ps
// --------------------------------------------------
// Phase accumulator. Holds the frequency control
// word of the current burst and steps the phase.
// --------------------------------------------------

module sgen_phase_accu (
  input  logic             i_clk,
  input  logic             i_rst_an,
  input  logic             i_clr,
  input  logic             i_ena,
  input  sgen_pkg::phase_t i_fcw,
  output sgen_pkg::phase_t o_phase
);

  sgen_pkg::phase_t fcw_q;
  sgen_pkg::phase_t phase_q;

  // the word is taken together with the clear at burst start.
  always_ff @(posedge i_clk)
  begin
    if (i_clr)
    begin
      fcw_q <= i_fcw;
    end
  end

  // wrap-around modulo 2^16 is the intended phase behaviour.
  always_ff @(posedge i_clk or negedge i_rst_an)
  begin
    if (!i_rst_an)
    begin
      phase_q <= '0;
    end
    else if (i_clr)
    begin
      phase_q <= '0;
    end
    else if (i_ena)
    begin
      phase_q <= phase_q + fcw_q;
    end
  end

  assign o_phase = phase_q;

endmodule

/* src/sgen_octant_rom.sv */
`timescale 1ns/1ps
// --------------------------------------------------
// First-octant sine and cosine tables, 255 scale.
// Returns the entry at the address and the next one.
// --------------------------------------------------
`include "sgen_defs.svh"

module sgen_octant_rom (
  input  sgen_pkg::rom_addr_t i_addr,
  output sgen_pkg::rom_data_t o_sin_mag,
  output sgen_pkg::rom_data_t o_cos_mag,
  output sgen_pkg::rom_data_t o_sin_next,
  output sgen_pkg::rom_data_t o_cos_next
);

  logic [`SGEN_ROM_AW:0] idx_cur;
  logic [`SGEN_ROM_AW:0] idx_nxt;

  // entry 32 is the 45 degree point where sine and cosine meet.
  function automatic logic [2*`SGEN_ROM_DW-1:0] lut(input logic [`SGEN_ROM_AW:0] idx);
    case (idx)
      0 : lut = {8'd0,   8'd255};
      1 : lut = {8'd6,   8'd255};
      2 : lut = {8'd13,  8'd255};
      3 : lut = {8'd19,  8'd254};
      4 : lut = {8'd25,  8'd254};
      5 : lut = {8'd31,  8'd253};
      6 : lut = {8'd37,  8'd252};
      7 : lut = {8'd44,  8'd251};
      8 : lut = {8'd50,  8'd250};
      9 : lut = {8'd56,  8'd249};
      10: lut = {8'd62,  8'd247};
      11: lut = {8'd68,  8'd246};
      12: lut = {8'd74,  8'd244};
      13: lut = {8'd80,  8'd242};
      14: lut = {8'd86,  8'd240};
      15: lut = {8'd92,  8'd238};
      16: lut = {8'd98,  8'd236};
      17: lut = {8'd103, 8'd233};
      18: lut = {8'd109, 8'd231};
      19: lut = {8'd115, 8'd228};
      20: lut = {8'd120, 8'd225};
      21: lut = {8'd126, 8'd222};
      22: lut = {8'd131, 8'd219};
      23: lut = {8'd136, 8'd215};
      24: lut = {8'd142, 8'd212};
      25: lut = {8'd147, 8'd208};
      26: lut = {8'd152, 8'd205};
      27: lut = {8'd157, 8'd201};
      28: lut = {8'd162, 8'd197};
      29: lut = {8'd167, 8'd193};
      30: lut = {8'd171, 8'd189};
      31: lut = {8'd176, 8'd185};
      32: lut = {8'd180, 8'd180};
      default: lut = '0;
    endcase
  endfunction

  // one extra index bit lets the last address reach the octant end.
  assign idx_cur = {1'b0, i_addr};
  assign idx_nxt = idx_cur + 1'b1;

  assign {o_sin_mag, o_cos_mag}   = lut(idx_cur);
  assign {o_sin_next, o_cos_next} = lut(idx_nxt);

endmodule

/* src/sgen_nco.sv */
`timescale 1ns/1ps
// --------------------------------------------------
// NCO waveform reconstruction. Builds full sine and
// cosine waves from the first-octant tables using
// octant sign, swap and mirror controls.
// --------------------------------------------------
`include "sgen_defs.svh"

module sgen_nco (
  input  sgen_pkg::phase_t i_phase,
  output sgen_pkg::wave_t  o_sin,
  output sgen_pkg::wave_t  o_cos
);

  logic [2:0]          octant;
  logic                mirror;
  logic                sin_sign;
  logic                sin_swap;
  logic                cos_sign;
  logic                cos_swap;
  sgen_pkg::rom_addr_t addr;
  sgen_pkg::rom_data_t sin_mag;
  sgen_pkg::rom_data_t cos_mag;
  sgen_pkg::rom_data_t sin_next;
  sgen_pkg::rom_data_t cos_next;

  // picks the table and entry for one wave and applies its sign.
  function automatic sgen_pkg::wave_t rebuild(
    input logic                sign,
    input logic                swap,
    input logic                mirr,
    input sgen_pkg::rom_data_t s_mag,
    input sgen_pkg::rom_data_t c_mag,
    input sgen_pkg::rom_data_t s_nxt,
    input sgen_pkg::rom_data_t c_nxt
  );
    sgen_pkg::rom_data_t mag;
    sgen_pkg::wave_t     val;
    if (!swap)
    begin
      mag = mirr ? s_nxt : s_mag;
    end
    else
    begin
      mag = mirr ? c_nxt : c_mag;
    end
    val = $signed({1'b0, mag});
    return sign ? -val : val;
  endfunction

  assign octant = i_phase[`SGEN_PHASE_W-1 -: 3];

  // odd octants run backwards through the table.
  assign mirror = octant[0];
  assign addr   = mirror ? ~i_phase[`SGEN_PHASE_W-4 -: `SGEN_ROM_AW]
                         :  i_phase[`SGEN_PHASE_W-4 -: `SGEN_ROM_AW];

  // sine is negative in the lower half circle, cosine in the left half.
  assign sin_sign = octant[2];
  assign sin_swap = octant[1] ^ octant[0];
  assign cos_sign = octant[2] ^ octant[1];
  assign cos_swap = octant[1] ~^ octant[0];

  sgen_octant_rom rom0 (
    .i_addr     (addr),
    .o_sin_mag  (sin_mag),
    .o_cos_mag  (cos_mag),
    .o_sin_next (sin_next),
    .o_cos_next (cos_next)
  );

  assign o_sin = rebuild(sin_sign, sin_swap, mirror, sin_mag, cos_mag, sin_next, cos_next);
  assign o_cos = rebuild(cos_sign, cos_swap, mirror, sin_mag, cos_mag, sin_next, cos_next);

endmodule

/* src/sgen_out_stage.sv */
`timescale 1ns/1ps
// --------------------------------------------------
// Output stage. Attenuates both waves by an
// arithmetic shift and registers them with a
// valid strobe.
// --------------------------------------------------

module sgen_out_stage (
  input  logic             i_clk,
  input  logic             i_rst_an,
  input  logic             i_att_load,
  input  sgen_pkg::atten_t i_atten,
  input  logic             i_ena,
  input  sgen_pkg::wave_t  i_sin,
  input  sgen_pkg::wave_t  i_cos,
  output sgen_pkg::wave_t  o_sin,
  output sgen_pkg::wave_t  o_cos,
  output logic             o_valid
);

  sgen_pkg::atten_t att_q;

  // the shift is fixed for the whole burst.
  always_ff @(posedge i_clk or negedge i_rst_an)
  begin
    if (!i_rst_an)
    begin
      att_q <= '0;
    end
    else if (i_att_load)
    begin
      att_q <= i_atten;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_an)
  begin
    if (!i_rst_an)
    begin
      o_sin   <= '0;
      o_cos   <= '0;
      o_valid <= 1'b0;
    end
    else
    begin
      o_valid <= i_ena;
      if (i_ena)
      begin
        o_sin <= i_sin >>> att_q;
        o_cos <= i_cos >>> att_q;
      end
    end
  end

endmodule

/* src/sgen_top.sv */
`timescale 1ns/1ps
// --------------------------------------------------
// Burst sine/cosine generator top level. Joins the
// burst controller with the NCO datapath.
// --------------------------------------------------

module sgen_top (
  input  logic                 i_clk,
  input  logic                 i_rst_an,
  input  logic                 i_start,
  input  logic                 i_stop,
  input  sgen_pkg::phase_t     i_fcw,
  input  sgen_pkg::burst_len_t i_burst_len,
  input  sgen_pkg::atten_t     i_atten,
  output sgen_pkg::wave_t      o_sin,
  output sgen_pkg::wave_t      o_cos,
  output logic                 o_valid,
  output logic                 o_busy,
  output logic                 o_done
);

  logic             accu_clr;
  logic             accu_ena;
  sgen_pkg::phase_t phase;
  sgen_pkg::wave_t  nco_sin;
  sgen_pkg::wave_t  nco_cos;

  sgen_ctrl ctrl0 (
    .i_clk       (i_clk),
    .i_rst_an    (i_rst_an),
    .i_start     (i_start),
    .i_stop      (i_stop),
    .i_burst_len (i_burst_len),
    .o_accu_clr  (accu_clr),
    .o_accu_ena  (accu_ena),
    .o_busy      (o_busy),
    .o_done      (o_done)
  );

  sgen_phase_accu accu0 (
    .i_clk    (i_clk),
    .i_rst_an (i_rst_an),
    .i_clr    (accu_clr),
    .i_ena    (accu_ena),
    .i_fcw    (i_fcw),
    .o_phase  (phase)
  );

  sgen_nco nco0 (
    .i_phase (phase),
    .o_sin   (nco_sin),
    .o_cos   (nco_cos)
  );

  // attenuation is captured by the same pulse that clears the phase.
  sgen_out_stage out0 (
    .i_clk      (i_clk),
    .i_rst_an   (i_rst_an),
    .i_att_load (accu_clr),
    .i_atten    (i_atten),
    .i_ena      (accu_ena),
    .i_sin      (nco_sin),
    .i_cos      (nco_cos),
    .o_sin      (o_sin),
    .o_cos      (o_cos),
    .o_valid    (o_valid)
  );

endmodule

/* verification/sgen_chk.sv */
`timescale 1ns/1ps
// --------------------------------------------------
// Strobe protocol checker of the burst generator,
// bound to the top level.
// --------------------------------------------------

module sgen_chk (
  input logic i_clk,
  input logic i_rst_an,
  input logic i_stop,
  input logic i_valid,
  input logic i_busy,
  input logic i_done
);

  // the done strobe is a single-cycle pulse.
  done_one_cycle: assert property (@(posedge i_clk) disable iff (!i_rst_an)
    i_done |=> !i_done)
    else $error("o_done stayed high for more than one cycle");

  // samples only start while a burst is running.
  valid_needs_busy: assert property (@(posedge i_clk) disable iff (!i_rst_an)
    $rose(i_valid) |-> $past(i_busy))
    else $error("o_valid rose without a running burst");

  // a stop request ends the burst without a final sample.
  done_with_valid: assert property (@(posedge i_clk) disable iff (!i_rst_an)
    i_done |-> (i_valid || $past(i_stop)))
    else $error("o_done came without a final sample or a stop request");

endmodule

bind sgen_top sgen_chk chk0 (
  .i_clk    (i_clk),
  .i_rst_an (i_rst_an),
  .i_stop   (i_stop),
  .i_valid  (o_valid),
  .i_busy   (o_busy),
  .i_done   (o_done)
);

/* verification/sgen_tb.sv */
`timescale 1ns/1ps
// --------------------------------------------------
// Testbench of the burst sine/cosine generator.
// Reads burst commands and expected sample pairs
// from the stimulus file and checks every sample.
// --------------------------------------------------

module sgen_tb;

  localparam integer MAX_CYCLES = 5000;

  logic                 i_clk;
  logic                 i_rst_an;
  logic                 i_start;
  logic                 i_stop;
  sgen_pkg::phase_t     i_fcw;
  sgen_pkg::burst_len_t i_burst_len;
  sgen_pkg::atten_t     i_atten;
  sgen_pkg::wave_t      o_sin;
  sgen_pkg::wave_t      o_cos;
  logic                 o_valid;
  logic                 o_busy;
  logic                 o_done;

  integer           fd;
  integer           r;
  integer           n_cmd;
  integer           gap;
  integer           seed;
  integer           fcw_v;
  integer           len_v;
  integer           att_v;
  integer           stop_v;
  logic [63:0]      tok;
  logic [8*256-1:0] line_buf;

  sgen_top dut0 (
    .i_clk       (i_clk),
    .i_rst_an    (i_rst_an),
    .i_start     (i_start),
    .i_stop      (i_stop),
    .i_fcw       (i_fcw),
    .i_burst_len (i_burst_len),
    .i_atten     (i_atten),
    .o_sin       (o_sin),
    .o_cos       (o_cos),
    .o_valid     (o_valid),
    .o_busy      (o_busy),
    .o_done      (o_done)
  );

  always #5 i_clk = ~i_clk;

  task automatic fail_run(input string why);
    $display("%0s", why);
    $display("test failed");
    $fatal(1, "simulation stopped on the first failure");
  endtask

  task automatic check_value(input string name, input integer got, input integer exp);
    if (got !== exp)
    begin
      fail_run($sformatf("ERROR at time %0t: %0s is %0d, expected %0d",
                         $time, name, got, exp));
    end
  endtask

  // one burst from start to the cycle after its done pulse.
  task automatic run_burst(input integer fcw, input integer len, input integer att,
                           input integer stop_cnt);
    integer n_exp;
    integer n_valid;
    integer cycles;
    integer exp_sin;
    integer exp_cos;
    integer rd;
    logic   done_seen;
    logic   stop_sent;
    n_exp     = (len == 0) ? stop_cnt : len;
    n_valid   = 0;
    cycles    = 0;
    done_seen = 1'b0;
    stop_sent = 1'b0;
    i_fcw       = fcw;
    i_burst_len = len;
    i_atten     = att;
    i_start     = 1'b1;
    @(posedge i_clk);
    #1;
    i_start = 1'b0;
    check_value("o_busy", o_busy, 1);
    while (!done_seen)
    begin
      // in continuous mode the stop follows the requested number of samples.
      if ((len == 0) && !stop_sent && (n_valid == stop_cnt))
      begin
        i_stop    = 1'b1;
        stop_sent = 1'b1;
      end
      @(posedge i_clk);
      #1;
      i_stop = 1'b0;
      cycles = cycles + 1;
      if (cycles > MAX_CYCLES)
      begin
        fail_run("timeout: the burst produced no done pulse");
      end
      // samples arrive back to back from the first cycle, and a stop cycle adds none.
      check_value("o_valid", o_valid, stop_sent ? 0 : 1);
      if (stop_sent)
      begin
        check_value("o_done", o_done, 1);
      end
      if (o_valid)
      begin
        rd = $fscanf(fd, " %d %d", exp_sin, exp_cos);
        if (rd != 2)
        begin
          fail_run("the DUT delivered more samples than the stimulus file expects");
        end
        check_value("o_sin", o_sin, exp_sin);
        check_value("o_cos", o_cos, exp_cos);
        n_valid = n_valid + 1;
      end
      done_seen = o_done;
      if (!done_seen)
      begin
        check_value("o_busy", o_busy, 1);
      end
    end
    check_value("valid sample count", n_valid, n_exp);
    check_value("o_busy", o_busy, 0);
    @(posedge i_clk);
    #1;
    check_value("o_done", o_done, 0);
    check_value("o_valid", o_valid, 0);
    check_value("o_busy", o_busy, 0);
  endtask

  initial
  begin
    i_clk       = 1'b0;
    i_rst_an    = 1'b0;
    i_start     = 1'b0;
    i_stop      = 1'b0;
    i_fcw       = '0;
    i_burst_len = '0;
    i_atten     = '0;
    n_cmd       = 0;
    seed        = $urandom(32'h1647);
    fd = $fopen("verification/sgen_input.txt", "r");
    if (fd == 0)
    begin
      fail_run("cannot open the stimulus file verification/sgen_input.txt");
    end
    repeat (10) @(posedge i_clk);
    #1;
    check_value("o_valid", o_valid, 0);
    check_value("o_busy", o_busy, 0);
    check_value("o_done", o_done, 0);
    check_value("o_sin", o_sin, 0);
    check_value("o_cos", o_cos, 0);
    i_rst_an = 1'b1;
    while ($fscanf(fd, " %s", tok) == 1)
    begin
      if (tok == "#")
      begin
        r = $fgets(line_buf, fd);
      end
      else if (tok == "C")
      begin
        r = $fscanf(fd, " %h %d %d %d", fcw_v, len_v, att_v, stop_v);
        if (r != 4)
        begin
          fail_run("malformed burst command in the stimulus file");
        end
        run_burst(fcw_v, len_v, att_v, stop_v);
        n_cmd = n_cmd + 1;
        gap   = $urandom % 4;
        repeat (gap)
        begin
          @(posedge i_clk);
          #1;
        end
      end
      else
      begin
        fail_run("unexpected entry in the stimulus file, sample count mismatch");
      end
    end
    $fclose(fd);
    if (n_cmd > 0)
    begin
      $display("test passed");
      $finish;
    end
    else
    begin
      fail_run("no burst command found in the stimulus file");
    end
  end

endmodule

/* verification/sgen_input.txt */
# C <fcw hex> <burst length> <attenuation> <stop after, 0 for none>
# then the expected o_sin o_cos pairs of that burst in signed decimal
C 2000 8 0 0
0 255  180 180  255 0  180 -180
0 -255  -180 -180  -255 0  -180 180
C 1300 14 0 0
0 255  115 228  205 152  251 44
244 -74  185 -176  86 -240  -31 -253
-142 -212  -222 -126  -255 -13  -233 103
-162 197  -56 249
C 1300 6 1 0
0 127  57 114  102 76  125 22
122 -37  92 -88
C 2000 8 2 0
0 63  45 45  63 0  45 -45
0 -64  -45 -45  -64 0  -45 45
C 1300 0 3 10
0 31  14 28  25 19  31 5
30 -10  23 -22  10 -30  -4 -32
-18 -27  -28 -16
C 0100 3 0 0
0 255  6 255  13 255
C 5555 1 0 0
0 255

/* tb.f */
+incdir+src
src/sgen_pkg.sv
src/sgen_ctrl.sv
src/sgen_phase_accu.sv
src/sgen_octant_rom.sv
src/sgen_nco.sv
src/sgen_out_stage.sv
src/sgen_top.sv
verification/sgen_chk.sv
verification/sgen_tb.sv
